//--- vlog.f
+incdir+common
common/mprf_pkg.sv
common/rfbuf_if.sv
rfbuf/rfbuf_pack.sv
rfbuf/rfbuf_store.sv
design/rgfile.sv
design/rs_read.sv
design/mprf.sv
bench/tb_mprf.sv

//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_mprf
RTL_TOP    := mprf
FILELIST   := vlog.f
OBJ_DIR    := obj_dir
LOG        := sim.log
FLAGS      := --binary --timing -Wno-fatal --Mdir $(OBJ_DIR)
LINT_FLAGS := --lint-only -Wall --timing
PASS_MSG   := ALL CHECKS PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) -f $(FILELIST) --top-module $(TOP)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "simulation failed, see $(LOG)"; exit 1; }

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- bench/tb_mprf.sv
`timescale 1ns/10ps
`include "mprf_params.svh"

module tb_mprf;

	localparam int RAND_CYCLES = 2000;
	localparam int TEST_CYCLES = 5 + 80 + RAND_CYCLES;
	localparam int DEPTH       = `RFBUF_LEN + `EXEC_LEN;

	logic                            clk = 1'b0;
	logic                            rst;
	logic [`EXEC_LEN*`RGBIT-1:0]     rd_sel, rs0_sel, rs1_sel;
	logic [`EXEC_LEN*`MMCMB_OFF-1:0] rd_order;
	logic [`EXEC_LEN*`JCBUF_OFF-1:0] rd_level;
	logic [`EXEC_LEN*`XLEN-1:0]      rd_data, rs0_word, rs1_word;
	logic [`RGBIT-1:0]               mem_sel;
	logic [`XLEN-1:0]                mem_data;
	logic                            mem_release, level_decrease, clear_pipeline, level_clear;
	logic [`RFBUF_OFF-1:0]           rfbuf_alu_num;

	// shadow buffer, entry 0 oldest
	logic [`RGBIT-1:0] sh_sel [0:DEPTH-1];
	logic [`XLEN-1:0]  sh_data [0:DEPTH-1];
	int                sh_order [0:DEPTH-1];
	int                sh_level [0:DEPTH-1];
	int                sh_len = 0;
	logic [`XLEN-1:0]  sh_reg [0:31];

	integer            seed;
	logic              focus_on;
	logic [`RGBIT-1:0] focus_reg;
	int                sweep;

	mprf DUT (.*);

	always #5 clk = ~clk;

	// --------------------------------------------------------------------------
	// reference model
	function automatic int count_down(input int c, input logic en);
		return (en && c > 0) ? c - 1 : c;
	endfunction

	function automatic logic flushed(input int o, input int l);
		return (clear_pipeline && (o != 0 || l != 0)) || (level_clear && l != 0);
	endfunction

	function automatic void model_step();
		logic [`RGBIT-1:0] n_sel [0:DEPTH-1];
		logic [`XLEN-1:0]  n_data [0:DEPTH-1];
		int                n_order [0:DEPTH-1];
		int                n_level [0:DEPTH-1];
		int                n_len, gone, o, l;
		n_len = 0;
		gone  = 0;
		for (int i = 0; i < sh_len; i++) begin
			o = count_down(sh_order[i], mem_release);
			l = count_down(sh_level[i], level_decrease);
			if (o == 0 && l == 0 && gone < `RFINTO_LEN) begin
				sh_reg[sh_sel[i]] = sh_data[i];
				gone++;
			end else if (!flushed(o, l)) begin
				n_sel[n_len]   = sh_sel[i];
				n_data[n_len]  = sh_data[i];
				n_order[n_len] = o;
				n_level[n_len] = l;
				n_len++;
			end
		end
		// incoming lanes after the survivors
		for (int i = 0; i < `EXEC_LEN; i++) begin
			o = count_down(int'(rd_order[i*`MMCMB_OFF +: `MMCMB_OFF]), mem_release);
			l = count_down(int'(rd_level[i*`JCBUF_OFF +: `JCBUF_OFF]), level_decrease);
			if (rd_sel[i*`RGBIT +: `RGBIT] != '0 && !flushed(o, l)) begin
				n_sel[n_len]   = rd_sel[i*`RGBIT +: `RGBIT];
				n_data[n_len]  = rd_data[i*`XLEN +: `XLEN];
				n_order[n_len] = o;
				n_level[n_len] = l;
				n_len++;
			end
		end
		if (mem_sel != '0) begin
			sh_reg[mem_sel] = mem_data;
		end
		for (int i = 0; i < n_len; i++) begin
			sh_sel[i]   = n_sel[i];
			sh_data[i]  = n_data[i];
			sh_order[i] = n_order[i];
			sh_level[i] = n_level[i];
		end
		sh_len = n_len;
		if (rst) begin
			sh_len = 0;
			for (int r = 0; r < 32; r++) begin
				sh_reg[r] = '0;
			end
		end
	endfunction

	// memory write, then newest buffered copy, then register
	function automatic logic [`XLEN-1:0] expected_read(input logic [`RGBIT-1:0] sel);
		logic [`XLEN-1:0] v;
		v = sh_reg[sel];
		for (int j = 0; j < sh_len; j++) begin
			if (sh_sel[j] == sel) begin
				v = sh_data[j];
			end
		end
		if (mem_sel != '0 && mem_sel == sel) begin
			v = mem_data;
		end
		return (sel == '0) ? '0 : v;
	endfunction

	// --------------------------------------------------------------------------
	// checks
	task automatic abort_run();
		$display("CHECKS FAILED");
		$fatal(1, "stopped at the first error");
	endtask

	task automatic check_word(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp,
			input string what);
		if (got !== exp) begin
			$display("MISMATCH at %0t: %s read %h, expected %h", $time, what, got, exp);
			abort_run();
		end
	endtask

	task automatic check_len(input logic [`RFBUF_OFF-1:0] got,
			input logic [`RFBUF_OFF-1:0] exp);
		if (got !== exp) begin
			$display("MISMATCH at %0t: occupancy %0d, expected %0d", $time, got, exp);
			abort_run();
		end
	endtask

	// steps the model on the edge, then idles the inputs and picks read selects
	task automatic advance();
		logic [`EXEC_LEN*`RGBIT-1:0] a, b;
		@(posedge clk);
		model_step();
		for (int p = 0; p < `EXEC_LEN; p++) begin
			a[p*`RGBIT +: `RGBIT] = focus_on ? focus_reg : (`RGBIT)'(sweep + 2*p);
			b[p*`RGBIT +: `RGBIT] = focus_on ? focus_reg : (`RGBIT)'(sweep + 2*p + 1);
		end
		sweep = sweep + 2*`EXEC_LEN;
		rs0_sel        <= a;
		rs1_sel        <= b;
		rd_sel         <= '0;
		mem_sel        <= '0;
		mem_release    <= 1'b0;
		level_decrease <= 1'b0;
		clear_pipeline <= 1'b0;
		level_clear    <= 1'b0;
	endtask

	initial begin : compare
		forever begin
			@(negedge clk);
			if (rst === 1'b0) begin
				for (int i = 0; i < `EXEC_LEN; i++) begin
					check_word(rs0_word[i*`XLEN +: `XLEN], expected_read(rs0_sel[i*`RGBIT +: `RGBIT]),
						$sformatf("rs0 lane %0d x%0d", i, rs0_sel[i*`RGBIT +: `RGBIT]));
					check_word(rs1_word[i*`XLEN +: `XLEN], expected_read(rs1_sel[i*`RGBIT +: `RGBIT]),
						$sformatf("rs1 lane %0d x%0d", i, rs1_sel[i*`RGBIT +: `RGBIT]));
				end
				check_len(rfbuf_alu_num, (`RFBUF_OFF)'(sh_len));
			end
		end
	end

	initial begin : watchdog
		#(TEST_CYCLES * 10 + 500);
		$display("timeout: the run did not finish within %0d cycles", TEST_CYCLES);
		abort_run();
	end

	// --------------------------------------------------------------------------
	// stimulus
	initial begin : stimulus
		logic [31:0]                     r;
		logic [`EXEC_LEN*`RGBIT-1:0]     v_sel, v_rs0, v_rs1;
		logic [`EXEC_LEN*`MMCMB_OFF-1:0] v_order;
		logic [`EXEC_LEN*`JCBUF_OFF-1:0] v_level;
		logic [`EXEC_LEN*`XLEN-1:0]      v_data;
		seed = 56;
		rst = 1'b1;
		{rd_sel, rd_order, rd_level, rd_data, rs0_sel, rs1_sel} = '0;
		{mem_sel, mem_data, mem_release, level_decrease, clear_pipeline, level_clear} = '0;
		focus_on  = 1'b0;
		focus_reg = '0;
		sweep     = 0;
		repeat (5) advance();
		rst <= 1'b0;

		// forwarding, newest copy of x5 wins
		focus_on  = 1'b1;
		focus_reg = 5'd5;
		advance();
		rd_sel   <= {5'd7, 5'd5};
		rd_order <= {3'd2, 3'd3};
		rd_level <= {2'd0, 2'd1};
		rd_data  <= {32'h0000_b0b0, 32'h0000_a0a0};
		advance();
		rd_sel   <= {5'd0, 5'd5};
		rd_data  <= {32'h0, 32'h0000_c0c0};
		advance();
		@(negedge clk);
		check_word(rs1_word[`XLEN-1:0], 32'h0000_c0c0, "x5 newest buffered copy");
		check_len(rfbuf_alu_num, 4'd3);

		// retirement, four settle together
		advance();
		rd_sel   <= {5'd10, 5'd9};
		rd_order <= {3'd1, 3'd1};
		rd_level <= '0;
		rd_data  <= {32'h0000_1010, 32'h0000_0909};
		advance();
		rd_sel   <= {5'd12, 5'd11};
		rd_data  <= {32'h0000_1212, 32'h0000_1111};
		do begin
			advance();
			mem_release    <= 1'b1;
			level_decrease <= 1'b1;
		end while (sh_len != 0);
		advance();
		@(negedge clk);
		check_word(rs0_word[`XLEN-1:0], 32'h0000_c0c0, "x5 after retire");
		check_len(rfbuf_alu_num, '0);

		// memory write over a buffered copy
		focus_reg = 5'd9;
		advance();
		rd_sel   <= {5'd0, 5'd9};
		rd_order <= {3'd0, 3'd3};
		rd_data  <= {32'h0, 32'h0000_4848};
		advance();
		mem_sel  <= 5'd9;
		mem_data <= 32'h0000_3c3c;
		@(negedge clk);
		check_word(rs0_word[`XLEN-1:0], 32'h0000_3c3c, "x9 memory write over buffer");
		focus_reg = 5'd0;
		advance();
		mem_data <= 32'hffff_ffff;
		@(negedge clk);
		check_word(rs0_word[`XLEN-1:0], '0, "x0");

		// level_clear, then clear_pipeline
		focus_reg = 5'd9;
		advance();
		rd_sel   <= {5'd14, 5'd13};
		rd_order <= {3'd0, 3'd2};
		rd_level <= {2'd1, 2'd2};
		advance();
		level_clear <= 1'b1;
		advance();
		@(negedge clk);
		check_word(rs0_word[`XLEN-1:0], 32'h0000_4848, "x9 buffered after level_clear");
		check_len(rfbuf_alu_num, 4'd1);
		advance();
		clear_pipeline <= 1'b1;
		advance();
		@(negedge clk);
		check_word(rs0_word[`XLEN-1:0], 32'h0000_3c3c, "x9 after clear_pipeline");
		check_len(rfbuf_alu_num, '0);

		// random mix
		focus_on = 1'b0;
		for (int k = 0; k < RAND_CYCLES; k++) begin
			advance();
			for (int i = 0; i < `EXEC_LEN; i++) begin
				r = $random(seed);
				v_sel[i*`RGBIT +: `RGBIT]         = (r[2:0] < 3'd5) ? r[7:3] : '0;
				v_order[i*`MMCMB_OFF +: `MMCMB_OFF] = r[10:8];
				v_level[i*`JCBUF_OFF +: `JCBUF_OFF] = r[12:11];
				v_rs0[i*`RGBIT +: `RGBIT]         = r[17:13];
				v_rs1[i*`RGBIT +: `RGBIT]         = r[22:18];
				v_data[i*`XLEN +: `XLEN]          = $random(seed);
			end
			// no room for a full set of lanes
			if (sh_len + `EXEC_LEN > `RFBUF_LEN) begin
				v_sel = '0;
			end
			r = $random(seed);
			rd_sel         <= v_sel;
			rd_order       <= v_order;
			rd_level       <= v_level;
			rd_data        <= v_data;
			rs0_sel        <= v_rs0;
			rs1_sel        <= v_rs1;
			mem_release    <= r[0];
			level_decrease <= r[1];
			clear_pipeline <= (r[6:2] == '0);
			level_clear    <= (r[11:7] == '0);
			mem_sel        <= (r[13:12] == 2'b00) ? r[18:14] : '0;
			mem_data       <= $random(seed);
		end
		advance();
		@(negedge clk);
		#1;
		$display("ALL CHECKS PASSED");
		$finish;
	end

endmodule

//--- design/mprf.sv
`timescale 1ns/10ps
`include "mprf_params.svh"

module mprf (
	input  logic                            clk,
	input  logic                            rst,

	input  logic [`EXEC_LEN*`RGBIT-1:0]     rd_sel,
	input  logic [`EXEC_LEN*`MMCMB_OFF-1:0] rd_order,
	input  logic [`EXEC_LEN*`JCBUF_OFF-1:0] rd_level,
	input  logic [`EXEC_LEN*`XLEN-1:0]      rd_data,

	input  logic [`RGBIT-1:0]               mem_sel,
	input  logic [`XLEN-1:0]                mem_data,

	input  logic                            mem_release,
	input  logic                            level_decrease,
	input  logic                            clear_pipeline,
	input  logic                            level_clear,

	input  logic [`EXEC_LEN*`RGBIT-1:0]     rs0_sel,
	input  logic [`EXEC_LEN*`RGBIT-1:0]     rs1_sel,
	output logic [`EXEC_LEN*`XLEN-1:0]      rs0_word,
	output logic [`EXEC_LEN*`XLEN-1:0]      rs1_word,

	output logic [`RFBUF_OFF-1:0]           rfbuf_alu_num
);

	logic [`EXEC_LEN*`RGBIT-1:0]     inc_sel;
	logic [`EXEC_LEN*`MMCMB_OFF-1:0] inc_order;
	logic [`EXEC_LEN*`JCBUF_OFF-1:0] inc_level;
	logic [`EXEC_LEN*`XLEN-1:0]      inc_data;
	logic [`EXEC_OFF-1:0]            inc_len;
	logic [31*`XLEN-1:0]             reg_words;

	rfbuf_if rb ();

	rfbuf_pack u_pack (
		.rd_sel         (rd_sel),
		.rd_order       (rd_order),
		.rd_level       (rd_level),
		.rd_data        (rd_data),
		.mem_release    (mem_release),
		.level_decrease (level_decrease),
		.clear_pipeline (clear_pipeline),
		.level_clear    (level_clear),
		.inc_sel        (inc_sel),
		.inc_order      (inc_order),
		.inc_level      (inc_level),
		.inc_data       (inc_data),
		.inc_len        (inc_len)
	);

	rfbuf_store u_store (
		.clk            (clk),
		.rst            (rst),
		.inc_sel        (inc_sel),
		.inc_order      (inc_order),
		.inc_level      (inc_level),
		.inc_data       (inc_data),
		.inc_len        (inc_len),
		.mem_release    (mem_release),
		.level_decrease (level_decrease),
		.clear_pipeline (clear_pipeline),
		.level_clear    (level_clear),
		.rfbuf_alu_num  (rfbuf_alu_num),
		.rb             (rb)
	);

	rgfile u_rgfile (
		.clk       (clk),
		.rst       (rst),
		.mem_sel   (mem_sel),
		.mem_data  (mem_data),
		.rp        (rb.retire),
		.reg_words (reg_words)
	);

	// ------------------------------------------------------------------------
	// rs0 and rs1 per lane
	for (genvar i = 0; i < `EXEC_LEN; i++) begin : gen_lane
		rs_read u_rs0 (
			.rs_sel    (rs0_sel[i*`RGBIT +: `RGBIT]),
			.mem_sel   (mem_sel),
			.mem_data  (mem_data),
			.reg_words (reg_words),
			.vw        (rb.view),
			.rs_word   (rs0_word[i*`XLEN +: `XLEN])
		);

		rs_read u_rs1 (
			.rs_sel    (rs1_sel[i*`RGBIT +: `RGBIT]),
			.mem_sel   (mem_sel),
			.mem_data  (mem_data),
			.reg_words (reg_words),
			.vw        (rb.view),
			.rs_word   (rs1_word[i*`XLEN +: `XLEN])
		);
	end

endmodule

//--- design/rs_read.sv
`timescale 1ns/10ps
`include "mprf_params.svh"

module rs_read (
	input  logic [`RGBIT-1:0]   rs_sel,
	input  logic [`RGBIT-1:0]   mem_sel,
	input  logic [`XLEN-1:0]    mem_data,
	input  logic [31*`XLEN-1:0] reg_words,
	rfbuf_if.view               vw,
	output logic [`XLEN-1:0]    rs_word
);

	logic                  buf_hit;
	logic [`RFBUF_OFF-1:0] hit_idx;
	logic [`XLEN-1:0]      buf_word;
	logic [`XLEN-1:0]      reg_word;
	logic                  mem_hit;

	// newest match is the highest index
	always_comb begin
		buf_hit = 1'b0;
		hit_idx = '0;
		for (int j = 0; j < `RFBUF_LEN; j++) begin
			if (j < vw.buf_len && vw.buf_sel[j*`RGBIT +: `RGBIT] == rs_sel) begin
				buf_hit = 1'b1;
				hit_idx = (`RFBUF_OFF)'(j);
			end
		end
	end

	assign buf_word = vw.buf_data[hit_idx*`XLEN +: `XLEN];
	assign reg_word = (rs_sel == '0) ? '0 : reg_words[(rs_sel - 1'b1)*`XLEN +: `XLEN];
	assign mem_hit  = (mem_sel != '0) && (mem_sel == rs_sel);

	// memory, then buffer, then register
	assign rs_word = mem_hit ? mem_data : (buf_hit ? buf_word : reg_word);

endmodule

//--- design/rgfile.sv
`timescale 1ns/10ps
`include "mprf_params.svh"

module rgfile (
	input  logic                 clk,
	input  logic                 rst,
	input  logic [`RGBIT-1:0]    mem_sel,
	input  logic [`XLEN-1:0]     mem_data,
	rfbuf_if.retire              rp,
	output logic [31*`XLEN-1:0]  reg_words
);

	// x0 is not stored
	logic [`XLEN-1:0] regs [1:31];

	// ------------------------------------------------------------------------
	// retire slots first, memory write last so it wins
	for (genvar r = 1; r < 32; r++) begin : gen_reg
		always_ff @(posedge clk) begin
			if (rst) begin
				regs[r] <= '0;
			end else begin
				for (int n = 0; n < `RFINTO_LEN; n++) begin
					if (rp.away_sel[n*`RGBIT +: `RGBIT] == r) begin
						regs[r] <= rp.away_data[n*`XLEN +: `XLEN];
					end
				end
				if (mem_sel == r) begin
					regs[r] <= mem_data;
				end
			end
		end

		assign reg_words[(r-1)*`XLEN +: `XLEN] = regs[r];
	end

endmodule

//--- rfbuf/rfbuf_store.sv
`timescale 1ns/10ps
`include "mprf_params.svh"

module rfbuf_store
	import mprf_pkg::*;
(
	input  logic                            clk,
	input  logic                            rst,
	input  logic [`EXEC_LEN*`RGBIT-1:0]     inc_sel,
	input  logic [`EXEC_LEN*`MMCMB_OFF-1:0] inc_order,
	input  logic [`EXEC_LEN*`JCBUF_OFF-1:0] inc_level,
	input  logic [`EXEC_LEN*`XLEN-1:0]      inc_data,
	input  logic [`EXEC_OFF-1:0]            inc_len,
	input  logic                            mem_release,
	input  logic                            level_decrease,
	input  logic                            clear_pipeline,
	input  logic                            level_clear,
	output logic [`RFBUF_OFF-1:0]           rfbuf_alu_num,
	rfbuf_if                                rb
);

	// buffer state, entry 0 is oldest
	logic [`RFBUF_LEN*`RGBIT-1:0]     sel_q;
	logic [`RFBUF_LEN*`MMCMB_OFF-1:0] order_q;
	logic [`RFBUF_LEN*`JCBUF_OFF-1:0] level_q;
	logic [`RFBUF_LEN*`XLEN-1:0]      data_q;
	logic [`RFBUF_OFF-1:0]            len_q;

	logic [`RFBUF_LEN*`MMCMB_OFF-1:0] order_up;
	logic [`RFBUF_LEN*`JCBUF_OFF-1:0] level_up;
	logic [`RFBUF_LEN-1:0]            settled;
	logic [`RFBUF_LEN-1:0]            flush;

	logic [`RFINTO_OFF-1:0]           away_cnt;
	logic [`RFINTO_LEN*`RGBIT-1:0]    ret_sel;
	logic [`RFINTO_LEN*`XLEN-1:0]     ret_data;

	logic [`RFBUF_OFF-1:0]            stay_cnt;
	logic [`RFBUF_LEN*`RGBIT-1:0]     stay_sel;
	logic [`RFBUF_LEN*`MMCMB_OFF-1:0] stay_order;
	logic [`RFBUF_LEN*`JCBUF_OFF-1:0] stay_level;
	logic [`RFBUF_LEN*`XLEN-1:0]      stay_data;

	// ------------------------------------------------------------------------
	// ticked counts and flush per entry
	for (genvar i = 0; i < `RFBUF_LEN; i++) begin : gen_tick
		assign order_up[i*`MMCMB_OFF +: `MMCMB_OFF] =
			age_order(order_q[i*`MMCMB_OFF +: `MMCMB_OFF], mem_release);
		assign level_up[i*`JCBUF_OFF +: `JCBUF_OFF] =
			age_level(level_q[i*`JCBUF_OFF +: `JCBUF_OFF], level_decrease);
		assign settled[i] = is_settled(order_up[i*`MMCMB_OFF +: `MMCMB_OFF],
			level_up[i*`JCBUF_OFF +: `JCBUF_OFF]);
		assign flush[i] = (clear_pipeline && !settled[i]) ||
			(level_clear && level_up[i*`JCBUF_OFF +: `JCBUF_OFF] != '0);
	end

	// ------------------------------------------------------------------------
	// split into retire slots and stay positions, oldest first
	always_comb begin
		away_cnt   = '0;
		ret_sel    = '0;
		ret_data   = '0;
		stay_cnt   = '0;
		stay_sel   = '0;
		stay_order = '0;
		stay_level = '0;
		stay_data  = '0;
		for (int i = 0; i < `RFBUF_LEN; i++) begin
			if (i < len_q) begin
				if (settled[i] && away_cnt < `RFINTO_LEN) begin
					ret_sel[away_cnt*`RGBIT +: `RGBIT] = sel_q[i*`RGBIT +: `RGBIT];
					ret_data[away_cnt*`XLEN +: `XLEN] = data_q[i*`XLEN +: `XLEN];
					away_cnt = away_cnt + 1'b1;
				end else if (!flush[i]) begin
					// settled past the limit lands here too
					stay_sel[stay_cnt*`RGBIT +: `RGBIT] = sel_q[i*`RGBIT +: `RGBIT];
					stay_order[stay_cnt*`MMCMB_OFF +: `MMCMB_OFF] =
						order_up[i*`MMCMB_OFF +: `MMCMB_OFF];
					stay_level[stay_cnt*`JCBUF_OFF +: `JCBUF_OFF] =
						level_up[i*`JCBUF_OFF +: `JCBUF_OFF];
					stay_data[stay_cnt*`XLEN +: `XLEN] = data_q[i*`XLEN +: `XLEN];
					stay_cnt = stay_cnt + 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			len_q <= '0;
		end else begin
			len_q <= stay_cnt + (`RFBUF_OFF)'(inc_len);
		end
	end

	// incoming lanes go after the survivors
	always_ff @(posedge clk) begin
		sel_q   <= stay_sel | ((`RFBUF_LEN*`RGBIT)'(inc_sel) << (stay_cnt*`RGBIT));
		order_q <= stay_order |
			((`RFBUF_LEN*`MMCMB_OFF)'(inc_order) << (stay_cnt*`MMCMB_OFF));
		level_q <= stay_level |
			((`RFBUF_LEN*`JCBUF_OFF)'(inc_level) << (stay_cnt*`JCBUF_OFF));
		data_q  <= stay_data | ((`RFBUF_LEN*`XLEN)'(inc_data) << (stay_cnt*`XLEN));
	end

	assign rb.buf_sel   = sel_q;
	assign rb.buf_data  = data_q;
	assign rb.buf_len   = len_q;
	assign rb.away_sel  = ret_sel;
	assign rb.away_data = ret_data;

	assign rfbuf_alu_num = len_q;

endmodule

//--- rfbuf/rfbuf_pack.sv
`timescale 1ns/10ps
`include "mprf_params.svh"

module rfbuf_pack
	import mprf_pkg::*;
(
	input  logic [`EXEC_LEN*`RGBIT-1:0]     rd_sel,
	input  logic [`EXEC_LEN*`MMCMB_OFF-1:0] rd_order,
	input  logic [`EXEC_LEN*`JCBUF_OFF-1:0] rd_level,
	input  logic [`EXEC_LEN*`XLEN-1:0]      rd_data,
	input  logic                            mem_release,
	input  logic                            level_decrease,
	input  logic                            clear_pipeline,
	input  logic                            level_clear,
	output logic [`EXEC_LEN*`RGBIT-1:0]     inc_sel,
	output logic [`EXEC_LEN*`MMCMB_OFF-1:0] inc_order,
	output logic [`EXEC_LEN*`JCBUF_OFF-1:0] inc_level,
	output logic [`EXEC_LEN*`XLEN-1:0]      inc_data,
	output logic [`EXEC_OFF-1:0]            inc_len
);

	logic [`EXEC_LEN*`MMCMB_OFF-1:0] order_up;
	logic [`EXEC_LEN*`JCBUF_OFF-1:0] level_up;
	logic [`EXEC_LEN-1:0]            lane_vld;
	logic [`EXEC_OFF-1:0]            pos;

	// ------------------------------------------------------------------------
	// per-lane tick and flush
	for (genvar i = 0; i < `EXEC_LEN; i++) begin : gen_lane
		assign order_up[i*`MMCMB_OFF +: `MMCMB_OFF] =
			age_order(rd_order[i*`MMCMB_OFF +: `MMCMB_OFF], mem_release);
		assign level_up[i*`JCBUF_OFF +: `JCBUF_OFF] =
			age_level(rd_level[i*`JCBUF_OFF +: `JCBUF_OFF], level_decrease);
		assign lane_vld[i] = (rd_sel[i*`RGBIT +: `RGBIT] != '0) &&
			!(clear_pipeline && !is_settled(order_up[i*`MMCMB_OFF +: `MMCMB_OFF],
				level_up[i*`JCBUF_OFF +: `JCBUF_OFF])) &&
			!(level_clear && level_up[i*`JCBUF_OFF +: `JCBUF_OFF] != '0);
	end

	// ------------------------------------------------------------------------
	// compact valid lanes to the low positions
	always_comb begin
		pos       = '0;
		inc_sel   = '0;
		inc_order = '0;
		inc_level = '0;
		inc_data  = '0;
		for (int i = 0; i < `EXEC_LEN; i++) begin
			if (lane_vld[i]) begin
				inc_sel[pos*`RGBIT +: `RGBIT] = rd_sel[i*`RGBIT +: `RGBIT];
				inc_order[pos*`MMCMB_OFF +: `MMCMB_OFF] = order_up[i*`MMCMB_OFF +: `MMCMB_OFF];
				inc_level[pos*`JCBUF_OFF +: `JCBUF_OFF] = level_up[i*`JCBUF_OFF +: `JCBUF_OFF];
				inc_data[pos*`XLEN +: `XLEN] = rd_data[i*`XLEN +: `XLEN];
				pos = pos + 1'b1;
			end
		end
		inc_len = pos;
	end

endmodule

//--- common/rfbuf_if.sv
`timescale 1ns/10ps
`include "mprf_params.svh"

interface rfbuf_if;

	// registered buffer contents, entry 0 is oldest
	logic [`RFBUF_LEN*`RGBIT-1:0]  buf_sel;
	logic [`RFBUF_LEN*`XLEN-1:0]   buf_data;
	logic [`RFBUF_OFF-1:0]         buf_len;

	// retire slots, select 0 when empty
	logic [`RFINTO_LEN*`RGBIT-1:0] away_sel;
	logic [`RFINTO_LEN*`XLEN-1:0]  away_data;

	modport view (
		input buf_sel,
		input buf_data,
		input buf_len
	);

	modport retire (
		input away_sel,
		input away_data
	);

endinterface

//--- common/mprf_pkg.sv
`include "mprf_params.svh"

package mprf_pkg;

	// order count ticks on mem_release, stops at zero
	function automatic logic [`MMCMB_OFF-1:0] age_order(
		input logic [`MMCMB_OFF-1:0] order,
		input logic                  mem_release
	);
		return (mem_release && order != '0) ? order - 1'b1 : order;
	endfunction

	// level count ticks on level_decrease, stops at zero
	function automatic logic [`JCBUF_OFF-1:0] age_level(
		input logic [`JCBUF_OFF-1:0] level,
		input logic                  level_decrease
	);
		return (level_decrease && level != '0) ? level - 1'b1 : level;
	endfunction

	// both ticked counts at zero
	function automatic logic is_settled(
		input logic [`MMCMB_OFF-1:0] order_up,
		input logic [`JCBUF_OFF-1:0] level_up
	);
		return (order_up == '0) && (level_up == '0);
	endfunction

endpackage

//--- common/mprf_params.svh
`ifndef MPRF_PARAMS_SVH
`define MPRF_PARAMS_SVH

// datapath
`define XLEN        32
// register select, 0 is no register
`define RGBIT       5

// execution lanes
`define EXEC_LEN    2
`define EXEC_OFF    2

// result buffer
`define RFBUF_LEN   8
`define RFBUF_OFF   4

// retires per cycle
`define RFINTO_LEN  2
`define RFINTO_OFF  2

// order and level counts
`define MMCMB_OFF   3
`define JCBUF_OFF   2

`endif
